/* hdl/l2_cfg_pkg.sv */
`default_nettype none

package l2_cfg_pkg;

  // Byte address of the request port
  localparam int unsigned AddrWidth = 16;

  // One bus word and its byte strobes
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Number of byte-offset bits below the word address
  localparam int unsigned WordOffset = $clog2(StrbWidth);

  // Geometry of one SRAM macro, must stay in line with the cut model
  localparam int unsigned CutDataWidth = 32;
  localparam int unsigned CutStrbWidth = CutDataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  typedef logic [CutDataWidth-1:0] cut_data_t;
  typedef logic [CutStrbWidth-1:0] cut_strb_t;

endpackage

`default_nettype wire

/* hdl/l2_bus_pkg.sv */
`default_nettype none

package l2_bus_pkg;

  // Longest read burst in beats
  localparam int unsigned MaxBurst = 8;

  // Beat count minus one, as carried on len_i
  typedef logic [$clog2(MaxBurst)-1:0] burst_len_t;

  // Request port sequencing
  typedef enum logic {
    IDLE,
    BURST
  } port_state_e;

endpackage

`default_nettype wire

/* hdl/sram_cut.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_cut #(
  parameter int unsigned CutWords = 256
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [$clog2(CutWords)-1:0]   addr_i,
  input  l2_cfg_pkg::cut_data_t         wdata_i,
  input  l2_cfg_pkg::cut_strb_t         be_i,
  output l2_cfg_pkg::cut_data_t         rdata_o
);

  import l2_cfg_pkg::*;

  // Storage starts cleared in simulation
  cut_data_t mem_q [CutWords] = '{default: '0};
  cut_data_t rdata_q;

  // Byte-enabled write
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < CutStrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read word is registered and held until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hdl/l2_mem_array.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_mem_array #(
  parameter int unsigned NumBytes = 8192,
  parameter int unsigned CutWords = 256
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  l2_cfg_pkg::addr_t addr_i,
  input  l2_cfg_pkg::data_t wdata_i,
  input  l2_cfg_pkg::strb_t strb_i,
  output l2_cfg_pkg::data_t rdata_o
);

  import l2_cfg_pkg::*;

  // Cut grid derived from the word and cut geometry
  localparam int unsigned NumParCuts   = DataWidth / CutDataWidth;
  localparam int unsigned RowBytes     = NumParCuts * CutWords * CutStrbWidth;
  localparam int unsigned NumSerCuts   = NumBytes / RowBytes;

  // Address split: byte offset, word index inside a cut, row index
  localparam int unsigned WordIdxWidth = $clog2(CutWords);
  localparam int unsigned RowIdxOff    = WordOffset + WordIdxWidth;
  localparam int unsigned RowIdxWidth  = $clog2(NumSerCuts);

  typedef logic [WordIdxWidth-1:0] cut_addr_t;

  logic      [NumSerCuts-1:0]                 cut_req;
  cut_addr_t                                  cut_addr_d;
  cut_addr_t                                  cut_addr_q;
  cut_data_t [NumSerCuts-1:0][NumParCuts-1:0] cut_rdata;
  cut_data_t                 [NumParCuts-1:0] cut_wdata;
  cut_strb_t                 [NumParCuts-1:0] cut_be;

  // Cut address holds its last value between accesses
  assign cut_addr_d = req_i ? addr_i[RowIdxOff-1:WordOffset] : cut_addr_q;

  // Word and strobes slice evenly across the columns
  assign cut_wdata = wdata_i;
  assign cut_be    = strb_i;

  if (RowIdxWidth > 0) begin : gen_row_idx
    typedef logic [RowIdxWidth-1:0] row_idx_t;

    row_idx_t row_idx_d;
    row_idx_t row_idx_q;

    assign row_idx_d = req_i ? addr_i[RowIdxOff +: RowIdxWidth] : row_idx_q;

    // Only the addressed row sees the request
    always_comb begin
      cut_req            = '0;
      cut_req[row_idx_d] = req_i;
    end

    // Registered row picks the returning read data
    assign rdata_o = cut_rdata[row_idx_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        row_idx_q <= '0;
      end else begin
        row_idx_q <= row_idx_d;
      end
    end
  end else begin : gen_single_row
    assign cut_req = req_i;
    assign rdata_o = cut_rdata[0];
  end

  for (genvar r = 0; r < NumSerCuts; r++) begin : gen_rows
    for (genvar c = 0; c < NumParCuts; c++) begin : gen_cols
      sram_cut #(
        .CutWords (CutWords)
      ) i_cut (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (cut_req[r]),
        .we_i    (we_i),
        .addr_i  (cut_addr_d),
        .wdata_i (cut_wdata[c]),
        .be_i    (cut_be[c]),
        .rdata_o (cut_rdata[r][c])
      );
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cut_addr_q <= '0;
    end else begin
      cut_addr_q <= cut_addr_d;
    end
  end

  // Geometry checks at elaboration
  if (NumBytes == 0 || (NumBytes & (NumBytes - 1)) != 0) begin : gen_chk_num_bytes
    $error("NumBytes must be a power of 2");
  end
  if (CutWords == 0 || (CutWords & (CutWords - 1)) != 0) begin : gen_chk_cut_words
    $error("CutWords must be a power of 2");
  end
  if (DataWidth % CutDataWidth != 0) begin : gen_chk_cut_width
    $error("DataWidth must be a multiple of the cut width");
  end
  if (NumBytes < RowBytes || NumBytes % RowBytes != 0) begin : gen_chk_rows
    $error("NumBytes must be a whole number of cut rows");
  end
  if (RowIdxOff + RowIdxWidth > AddrWidth) begin : gen_chk_addr
    $error("Capacity does not fit the address width");
  end

  // A decoding slip would write two rows at once
  a_one_row_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(cut_req)
  ) else $error("More than one cut row requested");

endmodule

`default_nettype wire

/* hdl/l2_mem_port.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_mem_port #(
  parameter int unsigned NumBytes = 8192
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   we_i,
  input  l2_cfg_pkg::addr_t      addr_i,
  input  l2_cfg_pkg::data_t      wdata_i,
  input  l2_cfg_pkg::strb_t      strb_i,
  input  l2_bus_pkg::burst_len_t len_i,
  input  l2_cfg_pkg::data_t      mem_rdata_i,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output l2_cfg_pkg::addr_t      mem_addr_o,
  output l2_cfg_pkg::data_t      mem_wdata_o,
  output l2_cfg_pkg::strb_t      mem_strb_o,
  output logic                   rsp_valid_o,
  output l2_cfg_pkg::data_t      rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic                   busy_o
);

  import l2_cfg_pkg::*;
  import l2_bus_pkg::*;

  // Address step between beats, one word
  localparam addr_t BeatStride = addr_t'(1) << WordOffset;

  port_state_e state_q;
  port_state_e state_d;
  burst_len_t  beats_left_q;
  burst_len_t  beats_left_d;

  addr_t       addr_q;
  data_t       wdata_q;
  strb_t       strb_q;
  logic        we_q;

  logic        issue;
  logic        beat_in_range;
  logic        rsp_valid_q;
  logic        rsp_err_q;
  logic        rsp_data_q;

  // A beat goes out on every cycle spent in BURST
  assign issue         = (state_q == BURST);
  assign beat_in_range = 32'(addr_q) < NumBytes;

  always_comb begin
    state_d      = state_q;
    beats_left_d = beats_left_q;
    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d      = BURST;
          beats_left_d = we_i ? '0 : len_i;
        end
      end
      BURST: begin
        if (beats_left_q == '0) begin
          state_d = IDLE;
        end else begin
          beats_left_d = beats_left_q - 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Request payload, address advances once per beat
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      wdata_q <= wdata_i;
      strb_q  <= strb_i;
    end else if (issue) begin
      addr_q  <= addr_q + BeatStride;
    end
  end

  // Shadow of each beat lines up with the array's read latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      beats_left_q <= '0;
      rsp_valid_q  <= 1'b0;
      rsp_err_q    <= 1'b0;
      rsp_data_q   <= 1'b0;
    end else begin
      state_q      <= state_d;
      beats_left_q <= beats_left_d;
      rsp_valid_q  <= issue;
      rsp_err_q    <= issue && !beat_in_range;
      rsp_data_q   <= mem_req_o && !we_q;
    end
  end

  // Out-of-range beats never reach the array
  assign mem_req_o   = issue && beat_in_range;
  assign mem_we_o    = we_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;
  assign mem_strb_o  = strb_q;

  // Writes and error beats answer with zero data
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;
  assign rsp_rdata_o = rsp_data_q ? mem_rdata_i : '0;

  // Busy until the last response has gone out
  assign busy_o = issue || rsp_valid_q;

  // No back-pressure exists, so the host must wait for busy to drop
  a_no_req_while_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) req_i |-> !busy_o
  ) else $error("Request issued while port is busy");

  // Bursts are defined for reads only
  a_single_beat_write: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (req_i && we_i) |-> (len_i == '0)
  ) else $error("Write request with nonzero burst length");

endmodule

`default_nettype wire

/* hdl/l2_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_subsys_top #(
  parameter int unsigned NumBytes = 8192,
  parameter int unsigned CutWords = 256
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   we_i,
  input  l2_cfg_pkg::addr_t      addr_i,
  input  l2_cfg_pkg::data_t      wdata_i,
  input  l2_cfg_pkg::strb_t      strb_i,
  input  l2_bus_pkg::burst_len_t len_i,
  output logic                   rsp_valid_o,
  output l2_cfg_pkg::data_t      rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic                   busy_o
);

  import l2_cfg_pkg::*;

  // Port to array
  logic  mem_req;
  logic  mem_we;
  addr_t mem_addr;
  data_t mem_wdata;
  strb_t mem_strb;
  data_t mem_rdata;

  l2_mem_port #(
    .NumBytes (NumBytes)
  ) i_mem_port (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .strb_i      (strb_i),
    .len_i       (len_i),
    .mem_rdata_i (mem_rdata),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_strb_o  (mem_strb),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o),
    .busy_o      (busy_o)
  );

  l2_mem_array #(
    .NumBytes (NumBytes),
    .CutWords (CutWords)
  ) i_mem_array (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .strb_i  (mem_strb),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

/* verification/tb_l2_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_l2_subsys;

  import l2_cfg_pkg::*;
  import l2_bus_pkg::*;

  localparam int unsigned NumBytes = 8192;
  localparam int unsigned CutWords = 256;
  // One row of cuts spans the full word width
  localparam int unsigned RowBytes = (DataWidth / CutDataWidth) * CutWords * CutStrbWidth;
  localparam int unsigned NumRows  = NumBytes / RowBytes;
  // About 200 accesses of at most 10 cycles, doubled for margin
  localparam int unsigned MaxCycles = 4000;
  localparam strb_t StrbPatterns [8] = '{8'h01, 8'h80, 8'h0f, 8'hf0,
                                         8'h5a, 8'h3c, 8'h00, 8'h7e};

  typedef logic [$clog2(NumBytes)-1:0] byte_idx_t;

  logic       clk;
  logic       rst_n;
  logic       req;
  logic       we;
  addr_t      addr;
  data_t      wdata;
  strb_t      strb;
  burst_len_t len;
  logic       rsp_valid;
  data_t      rsp_rdata;
  logic       rsp_err;
  logic       busy;

  // Byte-wide mirror of the scratchpad
  logic [7:0]  ref_mem [NumBytes];
  string       test_name;
  int unsigned checks;
  int unsigned errors;
  int unsigned errors_at_start;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned cycle_cnt;

  l2_subsys_top #(
    .NumBytes (NumBytes),
    .CutWords (CutWords)
  ) uut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (req),
    .we_i        (we),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .strb_i      (strb),
    .len_i       (len),
    .rsp_valid_o (rsp_valid),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err),
    .busy_o      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MaxCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", MaxCycles);
    $display("Test failed");
    $finish;
  end

  function automatic data_t model_word(input addr_t a);
    data_t w;
    w = '0;
    for (int b = 0; b < StrbWidth; b++) begin
      w[b*8 +: 8] = ref_mem[byte_idx_t'(32'(a) + 32'(b))];
    end
    return w;
  endfunction

  // Out-of-range writes leave the mirror untouched
  function automatic void model_write(input addr_t a, input data_t d, input strb_t s);
    if (32'(a) < NumBytes) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (s[b]) ref_mem[byte_idx_t'(32'(a) + 32'(b))] = d[b*8 +: 8];
      end
    end
  endfunction

  task automatic expect_value(input string what, input data_t expected, input data_t actual);
    checks++;
    assert (actual === expected) else begin
      $display("** Error: %s %s expected %h actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic expect_flag(input string what, input logic expected, input logic actual);
    checks++;
    assert (actual === expected) else begin
      $display("** Error: %s %s expected %b actual %b", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // One request, then every response checked on its own cycle at k+2
  task automatic access(input logic wr, input addr_t start_addr, input data_t wr_data,
                        input strb_t wr_strb, input int unsigned beats_m1);
    addr_t beat_addr;
    logic  exp_err;
    data_t exp_data;
    @(posedge clk);
    req   <= 1'b1;
    we    <= wr;
    addr  <= start_addr;
    wdata <= wr_data;
    strb  <= wr_strb;
    len   <= burst_len_t'(beats_m1);
    @(posedge clk);
    req   <= 1'b0;
    // Beat 0 is inside the array here
    @(negedge clk);
    expect_flag("valid one cycle after request", 1'b0, rsp_valid);
    expect_flag("busy after request", 1'b1, busy);
    for (int unsigned k = 0; k <= beats_m1; k++) begin
      beat_addr = start_addr + addr_t'(k * 8);
      exp_err   = 32'(beat_addr) >= NumBytes;
      exp_data  = (wr || exp_err) ? '0 : model_word(beat_addr);
      @(negedge clk);
      expect_flag($sformatf("beat %0d valid", k), 1'b1, rsp_valid);
      expect_flag($sformatf("beat %0d busy", k), 1'b1, busy);
      expect_flag($sformatf("beat %0d err at %h", k, beat_addr), exp_err, rsp_err);
      expect_value($sformatf("beat %0d rdata at %h", k, beat_addr), exp_data, rsp_rdata);
    end
    @(negedge clk);
    expect_flag("valid after last beat", 1'b0, rsp_valid);
    expect_flag("busy after last beat", 1'b0, busy);
    if (wr) model_write(start_addr, wr_data, wr_strb);
  endtask

  task automatic write_word(input addr_t a, input data_t d, input strb_t s);
    access(1'b1, a, d, s, 0);
  endtask

  task automatic read_burst(input addr_t a, input int unsigned beats_m1);
    access(1'b0, a, '0, '0, beats_m1);
  endtask

  task automatic fill_random(input addr_t a, input int unsigned words);
    for (int unsigned j = 0; j < words; j++) begin
      write_word(a + addr_t'(j * 8), {$urandom, $urandom}, '1);
    end
  endtask

  function automatic addr_t random_word_addr(input int unsigned spare_words);
    return addr_t'($urandom_range(0, NumBytes / 8 - 1 - spare_words) * 8);
  endfunction

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != errors_at_start) tests_failed++;
    $display("%s: %s, %0d errors", test_name,
             (errors == errors_at_start) ? "ok" : "FAILED", errors - errors_at_start);
  endtask

  task automatic test_reset_state();
    start_test("reset_state");
    repeat (5) begin
      @(negedge clk);
      expect_flag("valid in reset", 1'b0, rsp_valid);
      expect_flag("busy in reset", 1'b0, busy);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      expect_flag("valid while idle", 1'b0, rsp_valid);
      expect_flag("busy while idle", 1'b0, busy);
    end
    finish_test();
  endtask

  task automatic test_full_words();
    addr_t addrs [16];
    start_test("full_words");
    foreach (addrs[i]) begin
      addrs[i] = random_word_addr(0);
      write_word(addrs[i], {$urandom, $urandom}, '1);
    end
    foreach (addrs[i]) read_burst(addrs[i], 0);
    finish_test();
  endtask

  task automatic test_byte_strobes();
    addr_t a;
    start_test("byte_strobes");
    foreach (StrbPatterns[i]) begin
      a = random_word_addr(0);
      write_word(a, 64'h0011_2233_4455_6677 ^ data_t'(i), '1);
      write_word(a, {$urandom, $urandom}, StrbPatterns[i]);
      read_burst(a, 0);
    end
    finish_test();
  endtask

  // First, second, middle and last word of every row of cuts
  task automatic test_tiling();
    addr_t addrs [$];
    start_test("tiling");
    for (int unsigned r = 0; r < NumRows; r++) begin
      addrs.push_back(addr_t'(r * RowBytes));
      addrs.push_back(addr_t'(r * RowBytes + 8));
      addrs.push_back(addr_t'(r * RowBytes + RowBytes / 2));
      addrs.push_back(addr_t'(r * RowBytes + RowBytes - 8));
    end
    foreach (addrs[i]) write_word(addrs[i], {$urandom, $urandom}, '1);
    foreach (addrs[i]) read_burst(addrs[i], 0);
    finish_test();
  endtask

  task automatic test_bursts();
    addr_t a;
    start_test("bursts");
    for (int unsigned i = 0; i < 12; i++) begin
      a = random_word_addr(MaxBurst);
      fill_random(a, i % MaxBurst + 1);
      read_burst(a, i % MaxBurst);
    end
    // Three beats below each row boundary, the rest above it
    for (int unsigned r = 1; r < NumRows; r++) begin
      a = addr_t'(r * RowBytes - 24);
      fill_random(a, MaxBurst);
      read_burst(a, MaxBurst - 1);
    end
    finish_test();
  endtask

  task automatic test_out_of_range();
    addr_t oob [3];
    addr_t alias_addr;
    start_test("out_of_range");
    oob[0] = addr_t'(NumBytes);
    oob[1] = addr_t'(NumBytes + 'h5a8);
    oob[2] = 16'hfff8;
    foreach (oob[i]) begin
      // Word that the dropped upper address bits would land on
      alias_addr = addr_t'(32'(oob[i]) % NumBytes);
      write_word(alias_addr, {$urandom, $urandom}, '1);
      write_word(oob[i], {$urandom, $urandom}, '1);
      read_burst(alias_addr, 0);
      read_burst(oob[i], 0);
    end
    fill_random(addr_t'(NumBytes - 24), 3);
    read_burst(addr_t'(NumBytes - 24), MaxBurst - 1);
    finish_test();
  endtask

  initial begin
    void'($urandom(32'he8f4_c48f));
    rst_n <= 1'b0;
    req   <= 1'b0;
    we    <= 1'b0;
    addr  <= '0;
    wdata <= '0;
    strb  <= '0;
    len   <= '0;
    foreach (ref_mem[i]) ref_mem[i] = 8'h00;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;

    test_reset_state();
    test_full_words();
    test_byte_strobes();
    test_tiling();
    test_bursts();
    test_out_of_range();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hdl/l2_cfg_pkg.sv
hdl/l2_bus_pkg.sv
hdl/sram_cut.sv
hdl/l2_mem_array.sv
hdl/l2_mem_port.sv
hdl/l2_subsys_top.sv
verification/tb_l2_subsys.sv

/* run.sh */
#!/bin/sh
# Build and run the L2 scratchpad testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_l2_subsys
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f compile.f \
  --top-module tb_l2_subsys \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
